// ==== verilog/dtim_pkg.sv ====
package dtim_pkg;

  // ####################
  // Word level types
  // ####################

  typedef logic [31:0] word_t;
  typedef logic [3:0] strb_t;

  // Controller states
  typedef enum logic [2:0] {
    st_init,
    st_idle,
    st_look,
    st_fill,
    st_pass,
    st_update,
    st_fence,
    st_wback
  } dtim_state_e;

  // ####################
  // Byte merge
  // ####################

  // Strobed bytes of new_word replace those of old_word
  function automatic word_t merge_bytes(
    input word_t old_word,
    input word_t new_word,
    input strb_t strb
  );
    word_t merged;
    merged = old_word;
    for (int i = 0; i < $bits(strb_t); i++) begin
      if (strb[i]) begin
        merged[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return merged;
  endfunction

endpackage

// ==== verilog/dtim_ram.sv ====
module dtim_ram #(
  parameter int depth_bits = 4,
  parameter type payload_t = logic
) (
  input  logic                  clk,
  input  logic                  wen,
  input  logic [depth_bits-1:0] waddr,
  input  payload_t              wdata,
  input  logic [depth_bits-1:0] raddr,
  output payload_t              rdata
);

  payload_t mem [2**depth_bits];

  // Write port
  always_ff @(posedge clk) begin
    if (wen) begin
      mem[waddr] <= wdata;
    end
  end

  // Registered read returns old data on a same-address write
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

// ==== verilog/dtim_tag_store.sv ====
module dtim_tag_store #(
  parameter int depth_bits = 4,
  parameter int line_bits = 2
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [depth_bits-1:0]             rd_index,
  input  logic [29-depth_bits-line_bits:0]  rd_tag,
  input  logic                              wen,
  input  logic [depth_bits-1:0]             waddr,
  input  logic [29-depth_bits-line_bits:0]  wtag,
  input  logic                              wlock,
  input  logic                              wdirty,
  output logic                              hit,
  output logic                              lock,
  output logic                              dirty,
  output logic [29-depth_bits-line_bits:0]  stored_tag
);

  localparam int tag_bits = 30 - depth_bits - line_bits;

  // One entry per index
  typedef struct packed {
    logic [tag_bits-1:0] tag;
    logic                lock;
    logic                dirty;
  } entry_t;

  entry_t              wentry;
  entry_t              rentry;
  logic [tag_bits-1:0] tag_q;

  assign wentry.tag = wtag;
  assign wentry.lock = wlock;
  assign wentry.dirty = wdirty;

  dtim_ram #(
    .depth_bits (depth_bits),
    .payload_t  (entry_t)
  ) i_ram (
    .clk   (clk),
    .wen   (wen),
    .waddr (waddr),
    .wdata (wentry),
    .raddr (rd_index),
    .rdata (rentry)
  );

  // Request tag follows the array read by one cycle
  always_ff @(posedge clk) begin
    if (!rst) begin
      tag_q <= '0;
    end else begin
      tag_q <= rd_tag;
    end
  end

  // ####################
  // Hit decision
  // ####################

  assign lock = rentry.lock;
  assign dirty = rentry.dirty;
  assign stored_tag = rentry.tag;

  // Lock doubles as the valid bit
  assign hit = rentry.lock && (rentry.tag == tag_q);

endmodule

// ==== verilog/dtim_line_store.sv ====
module dtim_line_store
  import dtim_pkg::*;
#(
  parameter int depth_bits = 4,
  parameter int line_bits = 2
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [depth_bits-1:0] rd_index,
  input  logic [line_bits-1:0]  word_sel,
  input  logic                  store_en,
  input  word_t                 wdata,
  input  strb_t                 wstrb,
  input  logic                  fill_en,
  input  word_t                 fill_data,
  input  logic [depth_bits-1:0] windex,
  output word_t                 rd_word
);

  localparam int line_w = 32 * (2**line_bits);

  typedef logic [line_w-1:0] line_t;

  line_t                ram_line;
  line_t                held_line;
  line_t                fwd_line;
  line_t                merged_line;
  line_t                fill_buf;
  line_t                fill_line;
  line_t                wline;
  logic                 line_wen;
  logic                 fwd_valid;
  logic [line_bits-1:0] fill_cnt;

  dtim_ram #(
    .depth_bits (depth_bits),
    .payload_t  (line_t)
  ) i_ram (
    .clk   (clk),
    .wen   (line_wen),
    .waddr (windex),
    .wdata (wline),
    .raddr (rd_index),
    .rdata (ram_line)
  );

  // A line written last cycle at the read index is not in ram_line yet
  assign held_line = fwd_valid ? fwd_line : ram_line;
  assign rd_word = held_line[32*word_sel +: 32];

  always_comb begin
    merged_line = held_line;
    merged_line[32*word_sel +: 32] = merge_bytes(held_line[32*word_sel +: 32], wdata, wstrb);
  end

  // ####################
  // Fill assembly
  // ####################

  // First word ends up in the low slot
  assign fill_line = {fill_data, fill_buf[line_w-1:32]};
  assign line_wen = store_en || (fill_en && (fill_cnt == '1));
  assign wline = store_en ? merged_line : fill_line;

  always_ff @(posedge clk) begin
    if (!rst) begin
      fill_cnt <= '0;
      fwd_valid <= 1'b0;
    end else begin
      if (fill_en) begin
        fill_cnt <= fill_cnt + 1'b1;
      end
      fwd_valid <= line_wen && (windex == rd_index);
    end
  end

  always_ff @(posedge clk) begin
    if (fill_en) begin
      fill_buf <= fill_line;
    end
    if (line_wen) begin
      fwd_line <= wline;
    end
  end

endmodule

// ==== verilog/dtim_ctrl.sv ====
module dtim_ctrl
  import dtim_pkg::*;
#(
  parameter int          depth_bits = 4,
  parameter int          line_bits = 2,
  parameter logic [31:0] base_addr = 32'h0000_1000,
  parameter logic [31:0] top_addr = 32'h0000_2000
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             req_valid,
  input  logic                             req_fence,
  input  word_t                            req_addr,
  input  word_t                            req_wdata,
  input  strb_t                            req_wstrb,
  output logic                             resp_ready,
  output word_t                            resp_rdata,
  output logic                             dmem_valid,
  output word_t                            dmem_addr,
  output word_t                            dmem_wdata,
  output strb_t                            dmem_wstrb,
  input  logic                             dmem_ready,
  input  word_t                            dmem_rdata,
  output logic [depth_bits-1:0]            rd_index,
  output logic [29-depth_bits-line_bits:0] rd_tag,
  output logic                             wen,
  output logic [depth_bits-1:0]            waddr,
  output logic [29-depth_bits-line_bits:0] wtag,
  output logic                             wlock,
  output logic                             wdirty,
  input  logic                             hit,
  input  logic                             lock,
  input  logic                             dirty,
  input  logic [29-depth_bits-line_bits:0] stored_tag,
  output logic [line_bits-1:0]             word_sel,
  output logic                             store_en,
  output word_t                            wdata,
  output strb_t                            wstrb,
  output logic                             fill_en,
  output word_t                            fill_data,
  output logic [depth_bits-1:0]            windex,
  input  word_t                            rd_word
);

  localparam int idx_lo = line_bits + 2;
  localparam int tag_lo = depth_bits + line_bits + 2;

  dtim_state_e             state;
  dtim_state_e             state_nxt;
  word_t                   cap_addr;
  word_t                   cap_wdata;
  strb_t                   cap_wstrb;
  logic                    cap_fence;
  logic                    pend;
  logic [depth_bits-1:0]   idx;
  logic [depth_bits-1:0]   idx_nxt;
  logic [line_bits-1:0]    cnt;
  logic [line_bits-1:0]    cnt_nxt;
  word_t                   rd_addr;
  logic [depth_bits-1:0]   cap_idx;
  logic [line_bits-1:0]    cap_word;
  logic                    is_store;
  logic                    in_window;
  logic                    beat_done;
  logic                    walk_last;
  logic                    walk_step;

  // ####################
  // Request capture
  // ####################

  always_ff @(posedge clk) begin
    if (req_valid) begin
      cap_addr <= req_addr;
      cap_wdata <= req_wdata;
      cap_wstrb <= req_wstrb;
      cap_fence <= req_fence;
    end
  end

  assign cap_idx = cap_addr[tag_lo-1:idx_lo];
  assign cap_word = cap_addr[idx_lo-1:2];
  assign is_store = |cap_wstrb;
  assign in_window = (cap_addr >= base_addr) && (cap_addr < top_addr);
  assign rd_addr = req_valid ? req_addr : cap_addr;
  assign beat_done = dmem_valid && dmem_ready;
  assign walk_last = (idx == '1);

  // Line store payload comes straight from the capture
  assign wdata = cap_wdata;
  assign wstrb = cap_wstrb;
  assign windex = cap_idx;
  assign fill_data = dmem_rdata;

  always_ff @(posedge clk) begin
    if (!rst) begin
      state <= st_init;
      idx <= '0;
      cnt <= '0;
      pend <= 1'b0;
    end else begin
      state <= state_nxt;
      idx <= idx_nxt;
      cnt <= cnt_nxt;
      // Request seen outside idle waits here
      if (state == st_idle) begin
        pend <= 1'b0;
      end else if (req_valid) begin
        pend <= 1'b1;
      end
    end
  end

  // ####################
  // State machine
  // ####################

  always_comb begin
    state_nxt = state;
    idx_nxt = idx;
    cnt_nxt = cnt;
    walk_step = 1'b0;
    rd_index = cap_idx;
    rd_tag = cap_addr[31:tag_lo];
    wen = 1'b0;
    waddr = cap_idx;
    wtag = cap_addr[31:tag_lo];
    wlock = 1'b0;
    wdirty = 1'b0;
    word_sel = cap_word;
    store_en = 1'b0;
    fill_en = 1'b0;
    resp_ready = 1'b0;
    resp_rdata = '0;
    case (state)
      st_init: begin
        walk_step = 1'b1;
      end
      st_idle: begin
        rd_index = rd_addr[tag_lo-1:idx_lo];
        rd_tag = rd_addr[31:tag_lo];
        if (req_valid || pend) begin
          state_nxt = st_look;
        end
      end
      st_look: begin
        if (cap_fence) begin
          rd_index = '0;
          idx_nxt = '0;
          state_nxt = st_fence;
        end else if (!in_window || (lock && !hit)) begin
          state_nxt = st_pass;
        end else if (!lock) begin
          cnt_nxt = '0;
          state_nxt = st_fill;
        end else begin
          resp_ready = 1'b1;
          resp_rdata = is_store ? '0 : rd_word;
          store_en = is_store;
          wen = is_store;
          wlock = 1'b1;
          wdirty = 1'b1;
          state_nxt = st_idle;
        end
      end
      st_fill: begin
        fill_en = beat_done;
        if (beat_done) begin
          cnt_nxt = cnt + 1'b1;
          if (cnt == '1) begin
            state_nxt = st_update;
          end
        end
      end
      st_update: begin
        // Filled line is forwarded by the line store this cycle
        wen = 1'b1;
        wlock = 1'b1;
        wdirty = is_store;
        store_en = is_store;
        resp_ready = 1'b1;
        resp_rdata = is_store ? '0 : rd_word;
        state_nxt = st_idle;
      end
      st_pass: begin
        if (beat_done) begin
          resp_ready = 1'b1;
          resp_rdata = is_store ? '0 : dmem_rdata;
          state_nxt = st_idle;
        end
      end
      st_fence: begin
        if (lock && dirty) begin
          rd_index = idx;
          cnt_nxt = '0;
          state_nxt = st_wback;
        end else begin
          walk_step = 1'b1;
        end
      end
      st_wback: begin
        rd_index = idx;
        word_sel = cnt;
        if (beat_done) begin
          cnt_nxt = cnt + 1'b1;
          walk_step = (cnt == '1);
        end
      end
      default: begin
        state_nxt = st_init;
      end
    endcase

    // Shared index walk clears one entry and reads the next
    if (walk_step) begin
      wen = 1'b1;
      waddr = idx;
      wtag = '0;
      wlock = 1'b0;
      wdirty = 1'b0;
      idx_nxt = idx + 1'b1;
      rd_index = idx + 1'b1;
      if (walk_last) begin
        state_nxt = st_idle;
        resp_ready = (state != st_init);
      end else if (state == st_wback) begin
        state_nxt = st_fence;
      end
    end
  end

  // ####################
  // Backing memory port
  // ####################

  always_comb begin
    dmem_valid = 1'b0;
    dmem_addr = cap_addr;
    dmem_wdata = '0;
    dmem_wstrb = '0;
    case (state)
      st_fill: begin
        dmem_valid = 1'b1;
        dmem_addr = {cap_addr[31:idx_lo], cnt, 2'b00};
      end
      st_pass: begin
        dmem_valid = 1'b1;
        dmem_wdata = cap_wdata;
        dmem_wstrb = cap_wstrb;
      end
      st_wback: begin
        dmem_valid = 1'b1;
        dmem_addr = {stored_tag, idx, cnt, 2'b00};
        dmem_wdata = rd_word;
        dmem_wstrb = '1;
      end
      default: begin
        dmem_valid = 1'b0;
      end
    endcase
  end

endmodule

// ==== verilog/dtim_top.sv ====
module dtim_top
  import dtim_pkg::*;
#(
  parameter int          depth_bits = 4,
  parameter int          line_bits = 2,
  parameter logic [31:0] base_addr = 32'h0000_1000,
  parameter logic [31:0] top_addr = 32'h0000_2000
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  req_valid,
  input  logic  req_fence,
  input  word_t req_addr,
  input  word_t req_wdata,
  input  strb_t req_wstrb,
  output logic  resp_ready,
  output word_t resp_rdata,
  output logic  dmem_valid,
  output word_t dmem_addr,
  output word_t dmem_wdata,
  output strb_t dmem_wstrb,
  input  logic  dmem_ready,
  input  word_t dmem_rdata
);

  // Tag store side
  logic [depth_bits-1:0]            rd_index;
  logic [29-depth_bits-line_bits:0] rd_tag;
  logic                             wen;
  logic [depth_bits-1:0]            waddr;
  logic [29-depth_bits-line_bits:0] wtag;
  logic                             wlock;
  logic                             wdirty;
  logic                             hit;
  logic                             lock;
  logic                             dirty;
  logic [29-depth_bits-line_bits:0] stored_tag;

  // Line store side
  logic [line_bits-1:0]             word_sel;
  logic                             store_en;
  word_t                            wdata;
  strb_t                            wstrb;
  logic                             fill_en;
  word_t                            fill_data;
  logic [depth_bits-1:0]            windex;
  word_t                            rd_word;

  dtim_tag_store #(
    .depth_bits (depth_bits),
    .line_bits  (line_bits)
  ) i_tag_store (
    .clk        (clk),
    .rst        (rst),
    .rd_index   (rd_index),
    .rd_tag     (rd_tag),
    .wen        (wen),
    .waddr      (waddr),
    .wtag       (wtag),
    .wlock      (wlock),
    .wdirty     (wdirty),
    .hit        (hit),
    .lock       (lock),
    .dirty      (dirty),
    .stored_tag (stored_tag)
  );

  dtim_line_store #(
    .depth_bits (depth_bits),
    .line_bits  (line_bits)
  ) i_line_store (
    .clk       (clk),
    .rst       (rst),
    .rd_index  (rd_index),
    .word_sel  (word_sel),
    .store_en  (store_en),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .fill_en   (fill_en),
    .fill_data (fill_data),
    .windex    (windex),
    .rd_word   (rd_word)
  );

  dtim_ctrl #(
    .depth_bits (depth_bits),
    .line_bits  (line_bits),
    .base_addr  (base_addr),
    .top_addr   (top_addr)
  ) i_ctrl (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_fence  (req_fence),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .req_wstrb  (req_wstrb),
    .resp_ready (resp_ready),
    .resp_rdata (resp_rdata),
    .dmem_valid (dmem_valid),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .dmem_ready (dmem_ready),
    .dmem_rdata (dmem_rdata),
    .rd_index   (rd_index),
    .rd_tag     (rd_tag),
    .wen        (wen),
    .waddr      (waddr),
    .wtag       (wtag),
    .wlock      (wlock),
    .wdirty     (wdirty),
    .hit        (hit),
    .lock       (lock),
    .dirty      (dirty),
    .stored_tag (stored_tag),
    .word_sel   (word_sel),
    .store_en   (store_en),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .fill_en    (fill_en),
    .fill_data  (fill_data),
    .windex     (windex),
    .rd_word    (rd_word)
  );

endmodule

// ==== dv/dtim_chk.sv ====
module dtim_chk
  import dtim_pkg::*;
(
  input logic        clk,
  input logic        rst,
  input logic        resp_ready,
  input logic        dmem_valid,
  input logic        dmem_ready,
  input word_t       dmem_addr,
  input word_t       dmem_wdata,
  input strb_t       dmem_wstrb,
  input dtim_state_e state
);

  // Failed assertions so far
  int fail_count = 0;

  // Both outputs quiet while reset is held
  assert property (@(posedge clk) !rst |-> !resp_ready && !dmem_valid)
    else begin
      $error("response or backing memory request while reset is held");
      fail_count++;
    end

  // Backing memory word held until its ready pulse
  assert property (@(posedge clk) disable iff (!rst)
    dmem_valid && !dmem_ready |=> dmem_valid && $stable(dmem_addr)
      && $stable(dmem_wdata) && $stable(dmem_wstrb))
    else begin
      $error("backing memory request changed before ready");
      fail_count++;
    end

  // No backing memory traffic while idle or looking up
  assert property (@(posedge clk) disable iff (!rst)
    (state == st_idle || state == st_look) |-> !dmem_valid)
    else begin
      $error("backing memory request in idle or lookup state");
      fail_count++;
    end

endmodule

bind dtim_ctrl dtim_chk i_chk (
  .clk        (clk),
  .rst        (rst),
  .resp_ready (resp_ready),
  .dmem_valid (dmem_valid),
  .dmem_ready (dmem_ready),
  .dmem_addr  (dmem_addr),
  .dmem_wdata (dmem_wdata),
  .dmem_wstrb (dmem_wstrb),
  .state      (state)
);

// ==== dv/dtim_tb.sv ====
module dtim_tb
  import dtim_pkg::*;
();

  localparam int          depth_bits = 4;
  localparam int          line_bits = 2;
  localparam logic [31:0] base_addr = 32'h0000_1000;
  localparam logic [31:0] top_addr = 32'h0000_2000;
  localparam int          idx_lo = line_bits + 2;
  localparam int          tag_lo = depth_bits + line_bits + 2;
  localparam int          num_reqs = 600;
  localparam int          max_cycles = num_reqs * 60;

  localparam int kind_hit = 0;
  localparam int kind_fill = 1;
  localparam int kind_pass = 2;
  localparam int kind_fence = 3;

  logic  clk;
  logic  rst;
  logic  req_valid;
  logic  req_fence;
  word_t req_addr;
  word_t req_wdata;
  strb_t req_wstrb;
  logic  resp_ready;
  word_t resp_rdata;
  logic  dmem_valid;
  word_t dmem_addr;
  word_t dmem_wdata;
  strb_t dmem_wstrb;
  logic  dmem_ready;
  word_t dmem_rdata;

  integer      seed;
  int          cycles;
  logic [31:0] delay_pool;
  int          delay_left;
  logic        delay_armed;

  // Reference and backing memories follow init_word until written
  word_t              ref_mem [word_t];
  word_t              back_mem [word_t];
  logic               locked [2**depth_bits];
  logic [31-tag_lo:0] lock_tag [2**depth_bits];

  // Backing memory transfers seen during one request
  word_t xfer_addr [$];
  word_t xfer_wdata [$];
  strb_t xfer_wstrb [$];

  dtim_top #(
    .depth_bits (depth_bits),
    .line_bits  (line_bits),
    .base_addr  (base_addr),
    .top_addr   (top_addr)
  ) i_dut (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_fence  (req_fence),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .req_wstrb  (req_wstrb),
    .resp_ready (resp_ready),
    .resp_rdata (resp_rdata),
    .dmem_valid (dmem_valid),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .dmem_ready (dmem_ready),
    .dmem_rdata (dmem_rdata)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Timeout: no end of test after %0d cycles", max_cycles);
      $display("tests failed");
      $fatal(1, "timeout");
    end else begin
      check_value("assertion failures", 0, i_dut.i_ctrl.i_chk.fail_count);
    end
  end

  // ####################
  // Model helpers
  // ####################

  function automatic word_t init_word(word_t addr);
    return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
  endfunction

  function automatic word_t apply_strobe(word_t old_word, word_t new_word, strb_t strb);
    word_t result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  function automatic word_t ref_word(word_t addr);
    return ref_mem.exists(addr) ? ref_mem[addr] : init_word(addr);
  endfunction

  function automatic word_t back_word(word_t addr);
    return back_mem.exists(addr) ? back_mem[addr] : init_word(addr);
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Error at %0t: %s expected %h, got %h", $time, what, expected, actual);
      $display("tests failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // ####################
  // Backing memory
  // ####################

  // Two bits of delay_pool per word give a wait of 0 to 3 cycles
  always @(negedge clk) begin
    if (dmem_ready) begin
      dmem_ready = 1'b0;
      delay_armed = 1'b0;
    end else if (dmem_valid) begin
      if (!delay_armed) begin
        delay_left = delay_pool[1:0];
        delay_pool = {delay_pool[1:0], delay_pool[31:2]};
        delay_armed = 1'b1;
      end
      if (delay_left == 0) begin
        if (dmem_wstrb != '0) begin
          back_mem[dmem_addr] = apply_strobe(back_word(dmem_addr), dmem_wdata, dmem_wstrb);
        end
        dmem_rdata = back_word(dmem_addr);
        dmem_ready = 1'b1;
      end else begin
        delay_left = delay_left - 1;
      end
    end
  end

  // Every line locked before a fence must now match the reference
  task automatic check_fence_writeback();
    word_t a;
    for (int i = 0; i < 2**depth_bits; i++) begin
      if (locked[i]) begin
        for (int w = 0; w < 2**line_bits; w++) begin
          a = {lock_tag[i], {tag_lo{1'b0}}} + (i << idx_lo) + (w << 2);
          check_value("backing memory after fence", ref_word(a), back_word(a));
        end
      end
      locked[i] = 1'b0;
    end
  endtask

  task automatic run_request(input logic fence, input word_t addr, input word_t wdata,
                             input strb_t strb);
    int                    kind;
    logic [depth_bits-1:0] idx;
    logic [31-tag_lo:0]    tag;
    logic                  saw_valid;
    logic                  got;
    word_t                 rdata;
    word_t                 expected;
    word_t                 line_base;

    idx = addr[idx_lo +: depth_bits];
    tag = addr[31:tag_lo];
    line_base = {addr[31:idx_lo], {idx_lo{1'b0}}};
    if (fence) begin
      kind = kind_fence;
    end else if (addr < base_addr || addr >= top_addr || (locked[idx] && lock_tag[idx] != tag)) begin
      kind = kind_pass;
    end else if (!locked[idx]) begin
      kind = kind_fill;
    end else begin
      kind = kind_hit;
    end
    expected = (fence || strb != '0) ? '0 : ref_word(addr);
    xfer_addr.delete();
    xfer_wdata.delete();
    xfer_wstrb.delete();
    saw_valid = 1'b0;
    got = 1'b0;

    @(negedge clk);
    req_valid = 1'b1;
    req_fence = fence;
    req_addr = addr;
    req_wdata = wdata;
    req_wstrb = strb;
    delay_pool = $random(seed);
    @(posedge clk);
    @(negedge clk);
    req_valid = 1'b0;
    req_fence = 1'b0;
    while (!got) begin
      @(posedge clk);
      if (dmem_valid) begin
        saw_valid = 1'b1;
      end
      if (dmem_valid && dmem_ready) begin
        xfer_addr.push_back(dmem_addr);
        xfer_wdata.push_back(dmem_wdata);
        xfer_wstrb.push_back(dmem_wstrb);
      end
      if (resp_ready) begin
        got = 1'b1;
        rdata = resp_rdata;
      end
    end

    check_value("response data", expected, rdata);
    case (kind)
      kind_hit: begin
        check_value("backing memory activity on a hit", 0, saw_valid);
      end
      kind_fill: begin
        check_value("fill word count", 2**line_bits, xfer_addr.size());
        foreach (xfer_addr[k]) begin
          check_value("fill address", line_base + 4 * k, xfer_addr[k]);
          check_value("fill strobe", 0, xfer_wstrb[k]);
        end
        locked[idx] = 1'b1;
        lock_tag[idx] = tag;
      end
      kind_pass: begin
        check_value("pass-through word count", 1, xfer_addr.size());
        check_value("pass-through address", addr, xfer_addr[0]);
        check_value("pass-through strobe", strb, xfer_wstrb[0]);
        if (strb != '0) begin
          check_value("pass-through data", wdata, xfer_wdata[0]);
        end
      end
      default: begin
        check_fence_writeback();
      end
    endcase
    if (!fence && strb != '0) begin
      ref_mem[addr] = apply_strobe(ref_word(addr), wdata, strb);
    end
  endtask

  // ####################
  // Stimulus
  // ####################

  initial begin
    logic [31:0] rnd;
    logic [31:0] rnd2;
    word_t       addr;
    strb_t       strb;
    logic        fence;

    clk = 1'b0;
    rst = 1'b0;
    req_valid = 1'b0;
    req_fence = 1'b0;
    req_addr = '0;
    req_wdata = '0;
    req_wstrb = '0;
    dmem_ready = 1'b0;
    dmem_rdata = '0;
    cycles = 0;
    delay_pool = '0;
    delay_left = 0;
    delay_armed = 1'b0;
    seed = 32'h9e93_671a;
    for (int i = 0; i < 2**depth_bits; i++) begin
      locked[i] = 1'b0;
      lock_tag[i] = '0;
    end

    repeat (5) @(negedge clk);
    rst = 1'b1;

    // First request lands in the clear walk and waits there
    for (int n = 0; n < num_reqs; n++) begin
      rnd = $random(seed);
      rnd2 = $random(seed);
      fence = (rnd2 % 40) == 0;
      if (rnd[2:0] == 3'd0) begin
        addr = rnd[3] ? {20'h00000, rnd[13:4], 2'b00} : {20'h00002, rnd[13:4], 2'b00};
      end else begin
        // Few tags on mostly low indexes
        addr = {20'h00001, 2'b00, rnd[5:4], rnd[6] ? rnd[10:7] : {2'b00, rnd[8:7]},
                rnd[12:11], 2'b00};
      end
      if (fence || rnd2[10]) begin
        strb = '0;
      end else begin
        strb = (rnd2[14:11] == '0) ? 4'hf : rnd2[14:11];
      end
      run_request(fence, addr, $random(seed), strb);
    end

    @(negedge clk);
    if (i_dut.i_ctrl.i_chk.fail_count == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("An assertion in the bound checker failed");
      $display("tests failed");
      $fatal(1, "assertion failure");
    end
  end

endmodule

// ==== compile.f ====
verilog/dtim_pkg.sv
verilog/dtim_ram.sv
verilog/dtim_tag_store.sv
verilog/dtim_line_store.sv
verilog/dtim_ctrl.sv
verilog/dtim_top.sv
dv/dtim_chk.sv
dv/dtim_tb.sv
